// ==== Bender.yml ====
package:
  name: pv_hash

sources:
  - rtl/pv_gen_pkg.sv
  - rtl/pv_pcr_store.sv
  - rtl/pv_gen_hash.sv
  - rtl/pv_block_buffer.sv
  - rtl/pv_fold_digest.sv
  - rtl/pv_hash_top.sv
  - target: simulation
    files:
      - testbench/pv_hash_checker.sv
      - testbench/tb_pv_hash.sv

// ==== rtl/pv_block_buffer.sv ====
/*
 * Block assembly buffer, written one dword per cycle
 * and presented to the digest engine as one packed block
 */
module pv_block_buffer #(
  parameter int BLOCK_W = 1024,
  parameter int DATA_W  = 32
) (
  input  logic                     clk,
  input  logic                     rst_b,
  input  pv_gen_pkg::pv_block_wr_t blk_wr_i,
  output logic [BLOCK_W-1:0]       block_o
);

  localparam int BLOCK_NO = BLOCK_W / DATA_W;

  // Dword 0 sits in the least significant position of the block
  logic [BLOCK_NO-1:0][DATA_W-1:0] dword_q;

  logic wr_hit;

  assign wr_hit = blk_wr_i.we & (blk_wr_i.offset < BLOCK_NO);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      dword_q <= '0;
    end else if (wr_hit) begin
      dword_q[blk_wr_i.offset] <= blk_wr_i.data;
    end
  end

  // The generator rewrites every dword before it hands the block over
  assign block_o = dword_q;

endmodule

// ==== rtl/pv_fold_digest.sv ====
/*
 * Folding digest engine with init/next/ready/digest-valid behaviour,
 * consuming one dword of the latched block per cycle
 */
module pv_fold_digest #(
  parameter int BLOCK_W = 1024,
  parameter int DATA_W  = 32
) (
  input  logic                             clk,
  input  logic                             rst_b,
  input  logic                             hash_init_i,
  input  logic                             hash_next_i,
  input  logic [BLOCK_W-1:0]               block_i,
  output logic                             core_ready_o,
  output logic                             core_digest_valid_o,
  output logic [pv_gen_pkg::PV_DATA_W-1:0] digest_o
);

  localparam int BLOCK_NO = BLOCK_W / DATA_W;
  localparam int CNT_W    = $clog2(BLOCK_NO);
  localparam int DIG_W    = pv_gen_pkg::PV_DATA_W;
  localparam int ROT      = pv_gen_pkg::PV_FOLD_ROT;

  logic [BLOCK_NO-1:0][DATA_W-1:0] block_q;
  logic                            load;
  logic                            busy_q;
  logic                            folded_q;
  logic [CNT_W-1:0]                cnt_q;
  logic [DIG_W-1:0]                digest_q;
  logic [DIG_W-1:0]                digest_rot;

  assign load = hash_init_i | hash_next_i;

  // Rotate left before adding the next dword
  assign digest_rot = {digest_q[DIG_W-ROT-1:0], digest_q[DIG_W-1:DIG_W-ROT]};

  // Block copy is taken on the handover edge so the buffer can refill at once
  always_ff @(posedge clk) begin
    if (load) begin
      block_q <= block_i;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      busy_q   <= 1'b0;
      folded_q <= 1'b0;
      cnt_q    <= '0;
      digest_q <= pv_gen_pkg::PV_DIGEST_IV;
    end else if (load) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
      if (hash_init_i) begin
        digest_q <= pv_gen_pkg::PV_DIGEST_IV;
        folded_q <= 1'b0;
      end
    end else if (busy_q) begin
      digest_q <= digest_rot + block_q[cnt_q];
      cnt_q    <= cnt_q + 1'b1;
      // Last dword of the block ends the busy phase
      if (cnt_q == CNT_W'(BLOCK_NO - 1)) begin
        busy_q   <= 1'b0;
        folded_q <= 1'b1;
      end
    end
  end

  assign core_ready_o        = ~busy_q;
  assign core_digest_valid_o = ~busy_q & folded_q;
  assign digest_o            = digest_q;

endmodule

// ==== rtl/pv_gen_hash.sv ====
/*
 * Message generator FSM: streams PCR dwords, nonce and padding
 * into the block buffer and hands full blocks to the digest engine
 */
module pv_gen_hash #(
  parameter int BLOCK_W = 1024,
  parameter int DATA_W  = 32
) (
  input  logic                                                  clk,
  input  logic                                                  rst_b,
  input  logic                                                  start_i,
  input  logic                                                  core_ready_i,
  input  logic                                                  core_digest_valid_i,
  input  logic [pv_gen_pkg::PV_SIZE_OF_NONCE/DATA_W-1:0][DATA_W-1:0] nonce_i,
  output pv_gen_pkg::pv_read_t                                  pv_read_o,
  input  pv_gen_pkg::pv_rd_resp_t                               pv_rd_resp_i,
  output pv_gen_pkg::pv_block_wr_t                              blk_wr_o,
  output logic                                                  hash_init_o,
  output logic                                                  hash_next_o,
  output logic                                                  busy_o,
  output logic                                                  done_o
);

  localparam int BLOCK_NO       = BLOCK_W / DATA_W;
  localparam int BLOCK_OFFSET_W = $clog2(BLOCK_NO);
  localparam int NONCE_DWORDS   = pv_gen_pkg::PV_SIZE_OF_NONCE / DATA_W;
  localparam int NONCE_OFFSET_W = $clog2(NONCE_DWORDS);
  localparam int MSG_LEN_W      = pv_gen_pkg::PV_MSG_LEN_W;
  localparam int LEN_DWORDS     = MSG_LEN_W / DATA_W;
  localparam int LEN_SEL_W      = $clog2(LEN_DWORDS);
  localparam int PAD_LEN_DWORD  = BLOCK_NO - LEN_DWORDS;

  // Message length in bits covers every PCR dword plus the nonce
  localparam logic [LEN_DWORDS-1:0][DATA_W-1:0] PAD_LENGTH = MSG_LEN_W'(
    pv_gen_pkg::PV_NUM_PCR * pv_gen_pkg::PV_NUM_DWORDS * pv_gen_pkg::PV_DATA_W
    + pv_gen_pkg::PV_SIZE_OF_NONCE);

  pv_gen_pkg::pv_gen_hash_state_e state_q, state_d;

  logic [BLOCK_OFFSET_W:0]                    block_offset_q, block_offset_d;
  logic                                       block_full;
  logic                                       block_we;
  logic                                       in_msg;
  logic                                       handover;
  logic                                       first_blk_q;
  logic [DATA_W-1:0]                          blk_data;
  logic [pv_gen_pkg::PV_ENTRY_ADDR_W-1:0]     read_entry_q, read_entry_d;
  logic [pv_gen_pkg::PV_ENTRY_SIZE_WIDTH-1:0] read_offset_q, read_offset_d;
  logic                                       inc_rd_ptr;
  logic                                       rst_rd_ptr;
  logic                                       entry_end;
  logic                                       last_pcr_dword;
  logic [NONCE_OFFSET_W-1:0]                  nonce_offset_q, nonce_offset_d;
  logic [NONCE_OFFSET_W-1:0]                  nonce_sel;
  logic [BLOCK_OFFSET_W-1:0]                  len_sel;

  // States that put message dwords into the buffer
  assign in_msg = state_q inside {pv_gen_pkg::BLOCK_0, pv_gen_pkg::BLOCK_N,
                                  pv_gen_pkg::NONCE, pv_gen_pkg::PAD_LD1,
                                  pv_gen_pkg::PAD_0S, pv_gen_pkg::PAD_LEN};

  assign block_full = (block_offset_q == BLOCK_NO);
  assign block_we   = in_msg & ~block_full;
  // A full block waits here until the engine can take it
  assign handover   = in_msg & block_full & core_ready_i;

  assign hash_init_o = handover & first_blk_q;
  assign hash_next_o = handover & ~first_blk_q;
  assign busy_o      = (state_q != pv_gen_pkg::IDLE);
  assign done_o      = (state_q == pv_gen_pkg::DONE);

  assign block_offset_d = handover ? '0 :
                          block_we ? block_offset_q + 1'b1 : block_offset_q;

  // PCR read pointer walks dwords within an entry, then entries
  assign entry_end = (read_offset_q == pv_gen_pkg::PV_ENTRY_SIZE_WIDTH'(
                       pv_gen_pkg::PV_NUM_DWORDS - 1));
  assign last_pcr_dword = entry_end &
                          (read_entry_q == pv_gen_pkg::PV_ENTRY_ADDR_W'(
                             pv_gen_pkg::PV_NUM_PCR - 1));
  assign inc_rd_ptr = (state_q inside {pv_gen_pkg::BLOCK_0, pv_gen_pkg::BLOCK_N}) &
                      ~block_full;
  assign rst_rd_ptr = inc_rd_ptr & last_pcr_dword;

  assign read_offset_d = (rst_rd_ptr | (inc_rd_ptr & entry_end)) ? '0 :
                         inc_rd_ptr ? read_offset_q + 1'b1 : read_offset_q;
  assign read_entry_d  = rst_rd_ptr ? '0 :
                         (inc_rd_ptr & entry_end) ? read_entry_q + 1'b1 : read_entry_q;

  assign nonce_offset_d = (state_q != pv_gen_pkg::NONCE) ? '0 :
                          block_we ? nonce_offset_q + 1'b1 : nonce_offset_q;

  // Nonce goes out most significant dword first, and so does the length
  assign nonce_sel = NONCE_OFFSET_W'(NONCE_DWORDS - 1) - nonce_offset_q;
  assign len_sel   = BLOCK_OFFSET_W'(BLOCK_NO - 1) - block_offset_q[BLOCK_OFFSET_W-1:0];

  always_comb begin
    state_d  = state_q;
    blk_data = '0;
    case (state_q)
      pv_gen_pkg::IDLE: begin
        if (start_i) state_d = pv_gen_pkg::BLOCK_0;
      end
      pv_gen_pkg::BLOCK_0, pv_gen_pkg::BLOCK_N: begin
        blk_data = pv_rd_resp_i.read_data;
        if (handover) state_d = pv_gen_pkg::BLOCK_N;
        else if (rst_rd_ptr) state_d = pv_gen_pkg::NONCE;
      end
      pv_gen_pkg::NONCE: begin
        blk_data = nonce_i[nonce_sel];
        if (block_we && nonce_offset_q == NONCE_OFFSET_W'(NONCE_DWORDS - 1)) begin
          state_d = pv_gen_pkg::PAD_LD1;
        end
      end
      pv_gen_pkg::PAD_LD1: begin
        blk_data = pv_gen_pkg::PV_PAD_MARKER;
        if (block_we) state_d = pv_gen_pkg::PAD_0S;
      end
      pv_gen_pkg::PAD_0S: begin
        // Zeros run on, across a block boundary if needed, up to the length field
        if (block_we && block_offset_q == PAD_LEN_DWORD - 1) state_d = pv_gen_pkg::PAD_LEN;
      end
      pv_gen_pkg::PAD_LEN: begin
        blk_data = PAD_LENGTH[len_sel[LEN_SEL_W-1:0]];
        if (handover) state_d = pv_gen_pkg::WT_LAST;
      end
      pv_gen_pkg::WT_LAST: begin
        if (core_digest_valid_i) state_d = pv_gen_pkg::DONE;
      end
      pv_gen_pkg::DONE: begin
        state_d = pv_gen_pkg::IDLE;
      end
      default: begin
        state_d = pv_gen_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q        <= pv_gen_pkg::IDLE;
      block_offset_q <= '0;
      first_blk_q    <= 1'b0;
      read_entry_q   <= '0;
      read_offset_q  <= '0;
      nonce_offset_q <= '0;
    end else begin
      state_q        <= state_d;
      block_offset_q <= block_offset_d;
      read_entry_q   <= read_entry_d;
      read_offset_q  <= read_offset_d;
      nonce_offset_q <= nonce_offset_d;
      // The first handover of a run starts a fresh digest
      if (state_q == pv_gen_pkg::IDLE && start_i) first_blk_q <= 1'b1;
      else if (handover) first_blk_q <= 1'b0;
    end
  end

  assign pv_read_o.read_entry  = read_entry_q;
  assign pv_read_o.read_offset = read_offset_q;

  assign blk_wr_o.we     = block_we;
  assign blk_wr_o.offset = block_offset_q[BLOCK_OFFSET_W-1:0];
  assign blk_wr_o.data   = blk_data;

endmodule

// ==== rtl/pv_gen_pkg.sv ====
/*
 * Shared sizes, constants, request and response structs
 * and the generator state encoding of the platform-value hash engine
 */
package pv_gen_pkg;

  localparam int PV_DATA_W           = 32;
  localparam int PV_NUM_PCR          = 8;
  localparam int PV_NUM_DWORDS       = 12;
  localparam int PV_ENTRY_ADDR_W     = 3;
  localparam int PV_ENTRY_SIZE_WIDTH = 4;
  localparam int PV_SIZE_OF_NONCE    = 256;

  // Offset of one dword inside the default 1024-bit block
  localparam int PV_BLK_OFFSET_W     = 5;

  // Message length field at the tail of the last block
  localparam int PV_MSG_LEN_W        = 128;

  localparam logic [PV_DATA_W-1:0] PV_PAD_MARKER = 32'h8000_0000;
  localparam logic [PV_DATA_W-1:0] PV_DIGEST_IV  = 32'h6a09_e667;
  localparam int                   PV_FOLD_ROT   = 5;

  typedef struct packed {
    logic [PV_ENTRY_ADDR_W-1:0]     read_entry;
    logic [PV_ENTRY_SIZE_WIDTH-1:0] read_offset;
  } pv_read_t;

  typedef struct packed {
    logic [PV_DATA_W-1:0] read_data;
  } pv_rd_resp_t;

  typedef struct packed {
    logic                           we;
    logic [PV_ENTRY_ADDR_W-1:0]     entry;
    logic [PV_ENTRY_SIZE_WIDTH-1:0] offset;
    logic [PV_DATA_W-1:0]           data;
  } pv_pcr_wr_t;

  typedef struct packed {
    logic                       we;
    logic [PV_BLK_OFFSET_W-1:0] offset;
    logic [PV_DATA_W-1:0]       data;
  } pv_block_wr_t;

  typedef enum logic [3:0] {
    IDLE    = 4'b0000,
    BLOCK_0 = 4'b0001,
    BLOCK_N = 4'b0011,
    NONCE   = 4'b0010,
    PAD_LD1 = 4'b0110,
    PAD_0S  = 4'b0111,
    PAD_LEN = 4'b0101,
    WT_LAST = 4'b0100,
    DONE    = 4'b1100
  } pv_gen_hash_state_e;

endpackage

// ==== rtl/pv_hash_top.sv ====
/*
 * Platform-value measurement top level: PCR store, message
 * generator, block buffer and folding digest engine
 */
module pv_hash_top #(
  parameter int BLOCK_W = 1024,
  parameter int DATA_W  = 32
) (
  input  logic                                                  clk,
  input  logic                                                  rst_b,
  input  logic                                                  start_i,
  input  pv_gen_pkg::pv_pcr_wr_t                                pcr_wr_i,
  input  logic [pv_gen_pkg::PV_SIZE_OF_NONCE/DATA_W-1:0][DATA_W-1:0] nonce_i,
  output logic                                                  busy_o,
  output logic                                                  done_o,
  output logic [pv_gen_pkg::PV_DATA_W-1:0]                      digest_o
);

  pv_gen_pkg::pv_read_t     pv_read;
  pv_gen_pkg::pv_rd_resp_t  pv_rd_resp;
  pv_gen_pkg::pv_block_wr_t blk_wr;

  logic [BLOCK_W-1:0] block;
  logic               hash_init;
  logic               hash_next;
  logic               core_ready;
  logic               core_digest_valid;

  pv_pcr_store u_pcr_store (
    .clk          (clk),
    .rst_b        (rst_b),
    .pcr_wr_i     (pcr_wr_i),
    .pv_read_i    (pv_read),
    .pv_rd_resp_o (pv_rd_resp)
  );

  pv_gen_hash #(
    .BLOCK_W (BLOCK_W),
    .DATA_W  (DATA_W)
  ) u_gen_hash (
    .clk                 (clk),
    .rst_b               (rst_b),
    .start_i             (start_i),
    .core_ready_i        (core_ready),
    .core_digest_valid_i (core_digest_valid),
    .nonce_i             (nonce_i),
    .pv_read_o           (pv_read),
    .pv_rd_resp_i        (pv_rd_resp),
    .blk_wr_o            (blk_wr),
    .hash_init_o         (hash_init),
    .hash_next_o         (hash_next),
    .busy_o              (busy_o),
    .done_o              (done_o)
  );

  pv_block_buffer #(
    .BLOCK_W (BLOCK_W),
    .DATA_W  (DATA_W)
  ) u_block_buffer (
    .clk      (clk),
    .rst_b    (rst_b),
    .blk_wr_i (blk_wr),
    .block_o  (block)
  );

  pv_fold_digest #(
    .BLOCK_W (BLOCK_W),
    .DATA_W  (DATA_W)
  ) u_fold_digest (
    .clk                 (clk),
    .rst_b               (rst_b),
    .hash_init_i         (hash_init),
    .hash_next_i         (hash_next),
    .block_i             (block),
    .core_ready_o        (core_ready),
    .core_digest_valid_o (core_digest_valid),
    .digest_o            (digest_o)
  );

endmodule

// ==== rtl/pv_pcr_store.sv ====
/*
 * PCR storage array with a software write port
 * and a combinational dword read port
 */
module pv_pcr_store (
  input  logic                    clk,
  input  logic                    rst_b,
  input  pv_gen_pkg::pv_pcr_wr_t  pcr_wr_i,
  input  pv_gen_pkg::pv_read_t    pv_read_i,
  output pv_gen_pkg::pv_rd_resp_t pv_rd_resp_o
);

  localparam int NUM_PCR    = pv_gen_pkg::PV_NUM_PCR;
  localparam int NUM_DWORDS = pv_gen_pkg::PV_NUM_DWORDS;

  logic [NUM_PCR-1:0][NUM_DWORDS-1:0][pv_gen_pkg::PV_DATA_W-1:0] pcr_q;

  logic wr_in_range;
  logic rd_in_range;

  // The offset field is wider than an entry, so the upper offsets are unused
  assign wr_in_range = (pcr_wr_i.offset < NUM_DWORDS) & (pcr_wr_i.entry < NUM_PCR);
  assign rd_in_range = (pv_read_i.read_offset < NUM_DWORDS) &
                       (pv_read_i.read_entry < NUM_PCR);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      pcr_q <= '0;
    end else if (pcr_wr_i.we && wr_in_range) begin
      pcr_q[pcr_wr_i.entry][pcr_wr_i.offset] <= pcr_wr_i.data;
    end
  end

  always_comb begin
    if (rd_in_range) begin
      pv_rd_resp_o.read_data = pcr_q[pv_read_i.read_entry][pv_read_i.read_offset];
    end else begin
      pv_rd_resp_o.read_data = '0;
    end
  end

endmodule

// ==== testbench/pv_hash_checker.sv ====
/*
 * Checker for the platform-value hash engine: compares digest_o at each
 * done_o pulse against queued reference values and watches busy/done
 */
module pv_hash_checker (
  input  logic                             clk,
  input  logic                             rst_b,
  input  logic                             start_i,
  input  logic                             busy_i,
  input  logic                             done_i,
  input  logic [pv_gen_pkg::PV_DATA_W-1:0] digest_i,
  output int                               error_cnt_o,
  output int                               check_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [pv_gen_pkg::PV_DATA_W-1:0] exp_q[$];
  logic                             seen_start;
  logic                             start_q;
  logic                             busy_d;
  logic                             done_d;

  initial begin
    error_cnt_o = 0;
    check_cnt_o = 0;
    busy_d      = 1'b0;
    done_d      = 1'b0;
  end

  task automatic expect_digest(input logic [pv_gen_pkg::PV_DATA_W-1:0] value);
    exp_q.push_back(value);
  endtask

  task automatic count_failure(input string what);
    $display("%0d ns: %s", $time, what);
    error_cnt_o++;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("[ERROR] %0d ns: %s expected %08h, actual %08h", $time, name, exp_val, act_val);
    error_cnt_o++;
  endtask

  task automatic check_leftover();
    if (exp_q.size() != 0) begin
      count_failure($sformatf("%0d runs never produced a done_o pulse", exp_q.size()));
    end
  endtask

  // start_i is driven on the falling edge, so it is sampled on the rising one
  always @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      seen_start <= 1'b0;
      start_q    <= 1'b0;
    end else begin
      start_q <= start_i;
      if (start_i) seen_start <= 1'b1;
    end
  end

  always @(negedge clk) begin
    logic [pv_gen_pkg::PV_DATA_W-1:0] exp_val;
    if (rst_b) begin
      // Nothing may move before the first start
      if (!seen_start) begin
        if (busy_i !== 1'b0) count_failure("busy_o is high before the first start");
        if (done_i !== 1'b0) count_failure("done_o is high before the first start");
        if (digest_i !== pv_gen_pkg::PV_DIGEST_IV) begin
          report_mismatch("digest_o", pv_gen_pkg::PV_DIGEST_IV, digest_i);
        end
      end
      // A sampled start either begins a run or lands in one already going
      if (start_q && busy_i !== 1'b1) count_failure("busy_o is not high after a start_i pulse");
      if (done_i && busy_i !== 1'b1) count_failure("busy_o is low during the done_o pulse");
      if (done_i && done_d) begin
        count_failure("done_o stayed high for more than one cycle");
      end else if (done_i && exp_q.size() == 0) begin
        count_failure("done_o pulsed with no run outstanding");
      end else if (done_i) begin
        exp_val = exp_q.pop_front();
        check_cnt_o++;
        if (digest_i !== exp_val) report_mismatch("digest_o", exp_val, digest_i);
      end
      if (busy_d && !busy_i && !done_d) count_failure("busy_o fell without a done_o pulse");
      busy_d = busy_i;
      done_d = done_i;
    end else begin
      busy_d = 1'b0;
      done_d = 1'b0;
    end
  end

endmodule

// ==== testbench/tb_pv_hash.sv ====
/*
 * Testbench for the platform-value hash engine: clock, reset, stimulus,
 * reference digest model and watchdog
 */
module tb_pv_hash;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BLOCK_W      = 1024;
  localparam int DATA_W       = 32;
  localparam int NUM_PCR      = pv_gen_pkg::PV_NUM_PCR;
  localparam int NUM_DW       = pv_gen_pkg::PV_NUM_DWORDS;
  localparam int NONCE_DW     = pv_gen_pkg::PV_SIZE_OF_NONCE / DATA_W;
  localparam int BLK_DW       = BLOCK_W / DATA_W;
  localparam int LEN_DW       = 4;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RUNS     = 15;
  localparam int RUN_CYCLES   = 4 * 70 + 200;
  localparam int WATCHDOG_NS  = (NUM_RUNS * RUN_CYCLES + RESET_CYCLES) * CLK_PERIOD;

  typedef logic [NUM_PCR-1:0][NUM_DW-1:0][DATA_W-1:0] pcr_img_t;
  typedef logic [NONCE_DW-1:0][DATA_W-1:0]            nonce_t;

  logic                   clk;
  logic                   rst_b;
  logic                   start;
  pv_gen_pkg::pv_pcr_wr_t pcr_wr;
  nonce_t                 nonce;
  logic                   busy;
  logic                   done;
  logic [DATA_W-1:0]      digest;
  int                     error_cnt;
  int                     check_cnt;
  pcr_img_t               pcr_model;
  integer                 seed;

  pv_hash_top #(.BLOCK_W(BLOCK_W), .DATA_W(DATA_W)) u_pv_hash_top (
    .clk(clk), .rst_b(rst_b), .start_i(start), .pcr_wr_i(pcr_wr), .nonce_i(nonce),
    .busy_o(busy), .done_o(done), .digest_o(digest)
  );

  pv_hash_checker u_checker (
    .clk(clk), .rst_b(rst_b), .start_i(start), .busy_i(busy), .done_i(done),
    .digest_i(digest), .error_cnt_o(error_cnt), .check_cnt_o(check_cnt)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // PCR dwords, nonce high dword first, marker, zero pad, then 128-bit length
  function automatic logic [DATA_W-1:0] ref_digest(input pcr_img_t pcr, input nonce_t nv);
    logic [DATA_W-1:0] msg[$];
    logic [127:0]      len_bits;
    logic [DATA_W-1:0] dig;
    len_bits = 128'(NUM_PCR * NUM_DW * DATA_W + pv_gen_pkg::PV_SIZE_OF_NONCE);
    for (int e = 0; e < NUM_PCR; e++) begin
      for (int w = 0; w < NUM_DW; w++) msg.push_back(pcr[e][w]);
    end
    for (int i = NONCE_DW - 1; i >= 0; i--) msg.push_back(nv[i]);
    msg.push_back(32'h8000_0000);
    while (msg.size() % BLK_DW != BLK_DW - LEN_DW) msg.push_back('0);
    for (int i = LEN_DW - 1; i >= 0; i--) msg.push_back(len_bits[i*DATA_W +: DATA_W]);
    dig = pv_gen_pkg::PV_DIGEST_IV;
    for (int k = 0; k < msg.size(); k++) begin
      dig = ((dig << pv_gen_pkg::PV_FOLD_ROT) | (dig >> (DATA_W - pv_gen_pkg::PV_FOLD_ROT)))
            + msg[k];
    end
    return dig;
  endfunction

  task automatic write_pcr(input int entry, input int offset, input logic [DATA_W-1:0] data);
    pcr_wr.we     = 1'b1;
    pcr_wr.entry  = pv_gen_pkg::PV_ENTRY_ADDR_W'(entry);
    pcr_wr.offset = pv_gen_pkg::PV_ENTRY_SIZE_WIDTH'(offset);
    pcr_wr.data   = data;
    pcr_model[entry][offset] = data;
    @(negedge clk);
    pcr_wr.we = 1'b0;
  endtask

  task automatic fill_random_pcr();
    for (int e = 0; e < NUM_PCR; e++) begin
      for (int w = 0; w < NUM_DW; w++) write_pcr(e, w, $random(seed));
    end
  endtask

  // An extra start pulse is sent at cycle extra_start_at of the run, -1 for none
  task automatic run_measure(input int extra_start_at);
    int cnt;
    u_checker.expect_digest(ref_digest(pcr_model, nonce));
    start = 1'b1;
    @(negedge clk);
    cnt = 0;
    while (!done && cnt < RUN_CYCLES) begin
      start = (cnt == extra_start_at);
      @(negedge clk);
      cnt++;
    end
    start = 1'b0;
    if (!done) u_checker.count_failure("run did not reach done_o within its cycle budget");
    repeat (3) @(negedge clk);
  endtask

  initial begin
    int e_idx;
    int w_idx;
    seed      = 25621;
    rst_b     = 1'b0;
    start     = 1'b0;
    pcr_wr    = '0;
    nonce     = '0;
    pcr_model = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_b = 1'b1;
    repeat (20) @(negedge clk);

    // Store is all zero after reset
    for (int i = 0; i < NONCE_DW; i++) nonce[i] = 32'h0101_0101 * (i + 1);
    run_measure(-1);

    repeat (10) begin
      fill_random_pcr();
      for (int i = 0; i < NONCE_DW; i++) nonce[i] = $random(seed);
      run_measure(-1);
    end

    e_idx = $unsigned($random(seed)) % NUM_PCR;
    w_idx = $unsigned($random(seed)) % NUM_DW;
    write_pcr(e_idx, w_idx, ~pcr_model[e_idx][w_idx]);
    run_measure(-1);
    w_idx = $unsigned($random(seed)) % NONCE_DW;
    nonce[w_idx] = ~nonce[w_idx];
    run_measure(-1);

    // Restart attempts early in the PCR phase and late near the last block
    run_measure(20);
    run_measure(140);

    @(posedge clk);
    u_checker.check_leftover();
    $display("Summary: %0d digest checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
rtl/pv_gen_pkg.sv
rtl/pv_pcr_store.sv
rtl/pv_gen_hash.sv
rtl/pv_block_buffer.sv
rtl/pv_fold_digest.sv
rtl/pv_hash_top.sv
testbench/pv_hash_checker.sv
testbench/tb_pv_hash.sv
